// File: Bender.yml
package:
  name: gfp8_bcv

sources:
  - src/gfp8_pkg.sv
  - src/nv_pair_if.sv
  - src/bcv_loop_ctrl.sv
  - src/nv_fetch.sv
  - src/nv_dot_pipe.sv
  - src/v_accumulator.sv
  - src/gfp8_bcv_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/gfp8_bcv_tb.sv

// File: list.f
+incdir+test
src/gfp8_pkg.sv
src/nv_pair_if.sv
src/bcv_loop_ctrl.sv
src/nv_fetch.sv
src/nv_dot_pipe.sv
src/v_accumulator.sv
src/gfp8_bcv_top.sv
test/gfp8_bcv_tb.sv

// File: src/bcv_loop_ctrl.sv
`timescale 1ns/1ps

module bcv_loop_ctrl import gfp8_pkg::*; (
    input  logic               i_clk,
    input  logic               i_reset_n,
    input  logic               i_tile_en,
    input  logic [DIM_W-1:0]   i_dim_b,
    input  logic [DIM_W-1:0]   i_dim_c,
    input  logic [DIM_W-1:0]   i_dim_v,
    input  logic [ADDR_W-1:0]  i_left_base_addr,
    input  logic [ADDR_W-1:0]  i_right_base_addr,
    output logic               o_fill_active,
    output logic [DIM_W-1:0]   o_b_idx,
    output logic [DIM_W-1:0]   o_c_idx,
    output logic [DIM_W-1:0]   o_v_idx,
    output logic [DIM_W-1:0]   o_dim_v,
    output logic [ADDR_W-1:0]  o_left_base,
    output logic [ADDR_W-1:0]  o_right_base,
    output logic               o_accum_en,
    output logic               o_accum_first,
    output logic               o_return_en,
    output logic               o_tile_done
);

    bcv_state_t                       state_q;
    bcv_state_t                       state_next;
    logic [$clog2(COMPUTE_LAT)-1:0]   phase_cnt;
    logic                             tile_en_q;
    logic                             tile_rise;
    logic [DIM_W-1:0]                 dim_b_q;
    logic [DIM_W-1:0]                 dim_c_q;
    logic                             last_v;
    logic                             last_pair;

    assign tile_rise = i_tile_en & ~tile_en_q;
    assign last_v    = (o_v_idx == o_dim_v - 1'b1);
    assign last_pair = (o_c_idx == dim_c_q - 1'b1) && (o_b_idx == dim_b_q - 1'b1);

    // ==============================
    // Next state
    // ==============================
    always_comb begin
        state_next = state_q;
        case (state_q)
            IDLE:    if (tile_rise) state_next = FILL;
            // Capture cycle plus strobe cycle
            FILL:    if (phase_cnt == 1) state_next = COMPUTE;
            COMPUTE: if (phase_cnt == COMPUTE_LAT - 1) state_next = ACCUM;
            ACCUM:   state_next = last_v ? RETURN : FILL;
            RETURN:  state_next = last_pair ? DONE : FILL;
            DONE:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            state_q     <= IDLE;
            phase_cnt   <= '0;
            tile_en_q   <= 1'b0;
            o_tile_done <= 1'b0;
        end else begin
            state_q     <= state_next;
            tile_en_q   <= i_tile_en;
            // Done follows the result strobe by one cycle
            o_tile_done <= (state_q == DONE);
            // Phase counter restarts on every state change
            if (state_next != state_q) begin
                phase_cnt <= '0;
            end else begin
                phase_cnt <= phase_cnt + 1'b1;
            end
        end
    end

    // ==============================
    // Dimensions and loop indices
    // ==============================
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            dim_b_q      <= '0;
            dim_c_q      <= '0;
            o_dim_v      <= '0;
            o_left_base  <= '0;
            o_right_base <= '0;
            o_b_idx      <= '0;
            o_c_idx      <= '0;
            o_v_idx      <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    // Edges outside IDLE never reach here
                    if (tile_rise) begin
                        dim_b_q      <= i_dim_b;
                        dim_c_q      <= i_dim_c;
                        o_dim_v      <= i_dim_v;
                        o_left_base  <= i_left_base_addr;
                        o_right_base <= i_right_base_addr;
                        o_b_idx      <= '0;
                        o_c_idx      <= '0;
                        o_v_idx      <= '0;
                    end
                end
                ACCUM: begin
                    o_v_idx <= last_v ? '0 : o_v_idx + 1'b1;
                end
                RETURN: begin
                    // c is the inner of the two output loops
                    if (!last_pair) begin
                        if (o_c_idx == dim_c_q - 1'b1) begin
                            o_c_idx <= '0;
                            o_b_idx <= o_b_idx + 1'b1;
                        end else begin
                            o_c_idx <= o_c_idx + 1'b1;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // Strobes to fetch and accumulator
    assign o_fill_active = (state_q == FILL);
    assign o_accum_en    = (state_q == ACCUM);
    assign o_accum_first = (state_q == ACCUM) && (o_v_idx == '0);
    assign o_return_en   = (state_q == RETURN);

    // Zero dimensions are not supported
    a_dims_nonzero: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (state_q == IDLE && tile_rise) |-> (i_dim_b != 0 && i_dim_c != 0 && i_dim_v != 0));

    a_state_legal: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        state_q inside {IDLE, FILL, COMPUTE, ACCUM, RETURN, DONE});

endmodule

// File: src/gfp8_bcv_top.sv
`timescale 1ns/1ps

module gfp8_bcv_top import gfp8_pkg::*; (
    input  logic                       i_clk,
    input  logic                       i_reset_n,
    // Tile command
    input  logic                       i_tile_en,
    input  logic [DIM_W-1:0]           i_dim_b,
    input  logic [DIM_W-1:0]           i_dim_c,
    input  logic [DIM_W-1:0]           i_dim_v,
    input  logic [ADDR_W-1:0]          i_left_base_addr,
    input  logic [ADDR_W-1:0]          i_right_base_addr,
    output logic                       o_tile_done,
    // Tile memory, answered combinationally
    output logic [NV_IDX_W-1:0]        o_nv_left_rd_idx,
    input  nv_exp_u                    i_nv_left_exp,
    input  nv_group_u [NV_GROUPS-1:0]  i_nv_left_man,
    output logic [NV_IDX_W-1:0]        o_nv_right_rd_idx,
    input  nv_exp_u                    i_nv_right_exp,
    input  nv_group_u [NV_GROUPS-1:0]  i_nv_right_man,
    // One result per (b,c) pair
    output logic signed [ACC_W-1:0]    o_result_mantissa,
    output logic signed [EXP_W-1:0]    o_result_exponent,
    output logic                       o_result_valid
);

    logic                     fill_active;
    logic [DIM_W-1:0]         b_idx;
    logic [DIM_W-1:0]         c_idx;
    logic [DIM_W-1:0]         v_idx;
    logic [DIM_W-1:0]         dim_v;
    logic [ADDR_W-1:0]        left_base;
    logic [ADDR_W-1:0]        right_base;
    logic                     accum_en;
    logic                     accum_first;
    logic                     return_en;
    logic signed [ACC_W-1:0]  dot_mantissa;
    logic signed [EXP_W-1:0]  dot_exponent;

    nv_pair_if u_pair ();

    bcv_loop_ctrl u_ctrl (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_tile_en         (i_tile_en),
        .i_dim_b           (i_dim_b),
        .i_dim_c           (i_dim_c),
        .i_dim_v           (i_dim_v),
        .i_left_base_addr  (i_left_base_addr),
        .i_right_base_addr (i_right_base_addr),
        .o_fill_active     (fill_active),
        .o_b_idx           (b_idx),
        .o_c_idx           (c_idx),
        .o_v_idx           (v_idx),
        .o_dim_v           (dim_v),
        .o_left_base       (left_base),
        .o_right_base      (right_base),
        .o_accum_en        (accum_en),
        .o_accum_first     (accum_first),
        .o_return_en       (return_en),
        .o_tile_done       (o_tile_done)
    );

    nv_fetch u_fetch (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_fill_active     (fill_active),
        .i_b_idx           (b_idx),
        .i_c_idx           (c_idx),
        .i_v_idx           (v_idx),
        .i_dim_v           (dim_v),
        .i_left_base       (left_base),
        .i_right_base      (right_base),
        .o_nv_left_rd_idx  (o_nv_left_rd_idx),
        .o_nv_right_rd_idx (o_nv_right_rd_idx),
        .i_nv_left_exp     (i_nv_left_exp),
        .i_nv_right_exp    (i_nv_right_exp),
        .i_nv_left_man     (i_nv_left_man),
        .i_nv_right_man    (i_nv_right_man),
        .pair              (u_pair.src)
    );

    nv_dot_pipe u_dot (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .pair              (u_pair.dst),
        .o_dot_mantissa    (dot_mantissa),
        .o_dot_exponent    (dot_exponent)
    );

    v_accumulator u_accum (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_accum_en        (accum_en),
        .i_accum_first     (accum_first),
        .i_return_en       (return_en),
        .i_dot_mantissa    (dot_mantissa),
        .i_dot_exponent    (dot_exponent),
        .o_result_mantissa (o_result_mantissa),
        .o_result_exponent (o_result_exponent),
        .o_result_valid    (o_result_valid)
    );

endmodule

// File: src/gfp8_pkg.sv
package gfp8_pkg;

    // ==============================
    // Native vector geometry
    // ==============================
    localparam int NV_GROUPS    = 4;
    localparam int GROUP_ELEMS  = 4;
    localparam int MAN_W        = 8;
    localparam int GROUP_W      = 32;
    localparam int EXP_W        = 8;
    localparam int ACC_W        = 32;

    // Loop dimensions and tile memory addressing
    localparam int DIM_W        = 8;
    localparam int ADDR_W       = 9;
    localparam int NV_IDX_W     = 7;
    localparam int LINES_PER_NV = 4;

    // Number format and pipeline
    localparam int GFP_EXP_BIAS = 15;
    localparam int ALIGN_LIMIT  = 31;
    localparam int COMPUTE_LAT  = 4;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        FILL    = 3'd1,
        COMPUTE = 3'd2,
        ACCUM   = 3'd3,
        RETURN  = 3'd4,
        DONE    = 3'd5
    } bcv_state_t;

    // One group line, either raw or as four signed mantissas (element e in byte e)
    typedef union packed {
        logic [GROUP_W-1:0]                  flat;
        logic [GROUP_ELEMS-1:0][MAN_W-1:0]   man;
    } nv_group_u;

    // Exponent word of one NV, group g in byte g
    typedef union packed {
        logic [GROUP_W-1:0]                  flat;
        logic [NV_GROUPS-1:0][EXP_W-1:0]     exp;
    } nv_exp_u;

    // Aligned add of two mantissa/exponent pairs, returns {exponent, mantissa}
    function automatic logic [EXP_W+ACC_W-1:0] gfp_align_add(
        input logic signed [ACC_W-1:0] man_a,
        input logic signed [EXP_W-1:0] exp_a,
        input logic signed [ACC_W-1:0] man_b,
        input logic signed [EXP_W-1:0] exp_b
    );
        logic signed [EXP_W-1:0] max_exp;
        logic [EXP_W:0]          gap_a;
        logic [EXP_W:0]          gap_b;
        logic signed [ACC_W-1:0] al_a;
        logic signed [ACC_W-1:0] al_b;
        max_exp = (exp_a > exp_b) ? exp_a : exp_b;
        // Gap can reach 255, so one extra bit
        gap_a = {max_exp[EXP_W-1], max_exp} - {exp_a[EXP_W-1], exp_a};
        gap_b = {max_exp[EXP_W-1], max_exp} - {exp_b[EXP_W-1], exp_b};
        // Flush to zero past the shift limit
        if (gap_a > ALIGN_LIMIT) begin
            al_a = '0;
        end else begin
            al_a = man_a >>> gap_a;
        end
        if (gap_b > ALIGN_LIMIT) begin
            al_b = '0;
        end else begin
            al_b = man_b >>> gap_b;
        end
        return {max_exp, al_a + al_b};
    endfunction

endpackage

// File: src/nv_dot_pipe.sv
`timescale 1ns/1ps

module nv_dot_pipe import gfp8_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_reset_n,
    nv_pair_if.dst                   pair,
    output logic signed [ACC_W-1:0]  o_dot_mantissa,
    output logic signed [EXP_W-1:0]  o_dot_exponent
);

    // Stage strobes, last bit enables the output stage
    logic [COMPUTE_LAT-2:0]   stage_v;

    logic signed [2*MAN_W-1:0] prod_q     [NV_GROUPS][GROUP_ELEMS];
    logic signed [EXP_W-1:0]   exp1_q     [NV_GROUPS];
    logic signed [ACC_W-1:0]   grp_man_q  [NV_GROUPS];
    logic signed [EXP_W-1:0]   grp_exp_q  [NV_GROUPS];
    logic signed [ACC_W-1:0]   half_man_q [2];
    logic signed [EXP_W-1:0]   half_exp_q [2];

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            stage_v <= '0;
        end else begin
            stage_v <= {stage_v[COMPUTE_LAT-3:0], pair.valid};
        end
    end

    // ==============================
    // Datapath
    // ==============================
    always_ff @(posedge i_clk) begin
        // Stage 1 element products and unbiased group exponents
        if (pair.valid) begin
            for (int g = 0; g < NV_GROUPS; g++) begin
                for (int e = 0; e < GROUP_ELEMS; e++) begin
                    prod_q[g][e] <= $signed(pair.left_man[g].man[e]) *
                                    $signed(pair.right_man[g].man[e]);
                end
                exp1_q[g] <= pair.left_exp.exp[g] + pair.right_exp.exp[g] -
                             EXP_W'(2 * GFP_EXP_BIAS);
            end
        end
        // Stage 2 group sums, exponents carried along
        if (stage_v[0]) begin
            for (int g = 0; g < NV_GROUPS; g++) begin
                grp_man_q[g] <= prod_q[g][0] + prod_q[g][1] + prod_q[g][2] + prod_q[g][3];
                grp_exp_q[g] <= exp1_q[g];
            end
        end
        // Stage 3 fold groups 0/1 and 2/3
        if (stage_v[1]) begin
            {half_exp_q[0], half_man_q[0]} <= gfp_align_add(grp_man_q[0], grp_exp_q[0],
                                                            grp_man_q[1], grp_exp_q[1]);
            {half_exp_q[1], half_man_q[1]} <= gfp_align_add(grp_man_q[2], grp_exp_q[2],
                                                            grp_man_q[3], grp_exp_q[3]);
        end
        // Stage 4 final fold, held until the next pair
        if (stage_v[2]) begin
            {o_dot_exponent, o_dot_mantissa} <= gfp_align_add(half_man_q[0], half_exp_q[0],
                                                              half_man_q[1], half_exp_q[1]);
        end
    end

endmodule

// File: src/nv_fetch.sv
`timescale 1ns/1ps

module nv_fetch import gfp8_pkg::*; (
    input  logic                       i_clk,
    input  logic                       i_reset_n,
    input  logic                       i_fill_active,
    input  logic [DIM_W-1:0]           i_b_idx,
    input  logic [DIM_W-1:0]           i_c_idx,
    input  logic [DIM_W-1:0]           i_v_idx,
    input  logic [DIM_W-1:0]           i_dim_v,
    input  logic [ADDR_W-1:0]          i_left_base,
    input  logic [ADDR_W-1:0]          i_right_base,
    output logic [NV_IDX_W-1:0]        o_nv_left_rd_idx,
    output logic [NV_IDX_W-1:0]        o_nv_right_rd_idx,
    input  nv_exp_u                    i_nv_left_exp,
    input  nv_exp_u                    i_nv_right_exp,
    input  nv_group_u [NV_GROUPS-1:0]  i_nv_left_man,
    input  nv_group_u [NV_GROUPS-1:0]  i_nv_right_man,
    nv_pair_if.src                     pair
);

    logic [2*DIM_W-1:0] left_off;
    logic [2*DIM_W-1:0] right_off;
    logic               fill_q;
    logic               first_fill;

    // Row offsets in NV units, left walks b and right walks c
    assign left_off  = i_b_idx * i_dim_v + i_v_idx;
    assign right_off = i_c_idx * i_dim_v + i_v_idx;

    // Base converted from lines to NVs, sum wraps at 128
    assign o_nv_left_rd_idx  = i_fill_active ?
        NV_IDX_W'(i_left_base / LINES_PER_NV + left_off) : '0;
    assign o_nv_right_rd_idx = i_fill_active ?
        NV_IDX_W'(i_right_base / LINES_PER_NV + right_off) : '0;

    assign first_fill = i_fill_active & ~fill_q;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            fill_q     <= 1'b0;
            pair.valid <= 1'b0;
        end else begin
            fill_q     <= i_fill_active;
            // High in the second FILL cycle only
            pair.valid <= first_fill;
        end
    end

    // NV buffers, loaded once per V step
    always_ff @(posedge i_clk) begin
        if (first_fill) begin
            pair.left_exp  <= i_nv_left_exp;
            pair.left_man  <= i_nv_left_man;
            pair.right_exp <= i_nv_right_exp;
            pair.right_man <= i_nv_right_man;
        end
    end

    a_valid_single: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        pair.valid |=> !pair.valid);

endmodule

// File: src/nv_pair_if.sv
`timescale 1ns/1ps

interface nv_pair_if import gfp8_pkg::*; ();

    // Left and right NV as captured by the fetch stage
    nv_exp_u                     left_exp;
    nv_group_u [NV_GROUPS-1:0]   left_man;
    nv_exp_u                     right_exp;
    nv_group_u [NV_GROUPS-1:0]   right_man;

    // One-cycle strobe, data stable while high
    logic                        valid;

    modport src (
        output left_exp,
        output left_man,
        output right_exp,
        output right_man,
        output valid
    );

    modport dst (
        input  left_exp,
        input  left_man,
        input  right_exp,
        input  right_man,
        input  valid
    );

endinterface

// File: src/v_accumulator.sv
`timescale 1ns/1ps

module v_accumulator import gfp8_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_reset_n,
    input  logic                     i_accum_en,
    input  logic                     i_accum_first,
    input  logic                     i_return_en,
    input  logic signed [ACC_W-1:0]  i_dot_mantissa,
    input  logic signed [EXP_W-1:0]  i_dot_exponent,
    output logic signed [ACC_W-1:0]  o_result_mantissa,
    output logic signed [EXP_W-1:0]  o_result_exponent,
    output logic                     o_result_valid
);

    // Running value of the current (b,c) pair
    logic signed [ACC_W-1:0] acc_man;
    logic signed [EXP_W-1:0] acc_exp;

    always_ff @(posedge i_clk) begin
        if (i_accum_en) begin
            if (i_accum_first) begin
                acc_man <= i_dot_mantissa;
                acc_exp <= i_dot_exponent;
            end else begin
                {acc_exp, acc_man} <= gfp_align_add(acc_man, acc_exp,
                                                    i_dot_mantissa, i_dot_exponent);
            end
        end else if (i_return_en) begin
            acc_man <= '0;
            acc_exp <= '0;
        end
        // Result word, taken as the pair closes
        if (i_return_en) begin
            o_result_mantissa <= acc_man;
            o_result_exponent <= acc_exp;
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= i_return_en;
        end
    end

    a_en_exclusive: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(i_accum_en && i_return_en));

    // A pair always closes right after its last V step
    a_return_after_accum: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_return_en |-> $past(i_accum_en));

endmodule

// File: test/gfp8_ref_model.svh
`ifndef GFP8_REF_MODEL_SVH
`define GFP8_REF_MODEL_SVH

// Mantissa shifted down by an exponent gap or flushed once the gap is too large
function automatic int shift_or_flush(input int man, input int gap);
    if (gap > ALIGN_LIMIT) begin
        return 0;
    end
    return man >>> gap;
endfunction

// Sum of two mantissa/exponent pairs at the larger exponent
function automatic void aligned_sum(input int man_a, input int exp_a,
                                    input int man_b, input int exp_b,
                                    output int man_sum, output int exp_sum);
    int top;
    top = (exp_a >= exp_b) ? exp_a : exp_b;
    man_sum = shift_or_flush(man_a, top - exp_a) + shift_or_flush(man_b, top - exp_b);
    exp_sum = top;
endfunction

// Line base to NV base plus the loop position, wrapped inside the memory
function automatic int wrapped_nv_index(input int base, input int row, input int dim_v,
                                        input int v);
    return (base / LINES_PER_NV + row * dim_v + v) % NV_COUNT;
endfunction

// Dot product of two NVs from the tile memory arrays
function automatic void dot_of_nvs(input int left_nv, input int right_nv,
                                   output int man, output int exp);
    int grp_man [NV_GROUPS];
    int grp_exp [NV_GROUPS];
    int m01;
    int e01;
    int m23;
    int e23;
    for (int g = 0; g < NV_GROUPS; g++) begin
        grp_man[g] = 0;
        for (int e = 0; e < GROUP_ELEMS; e++) begin
            grp_man[g] += int'(man_mem[left_nv][g][e]) * int'(man_mem[right_nv][g][e]);
        end
        // Both biases removed from the group exponent
        grp_exp[g] = int'(exp_mem[left_nv][g]) + int'(exp_mem[right_nv][g]) - 2 * GFP_EXP_BIAS;
    end
    // Pairwise fold of groups 0/1 and 2/3 first
    aligned_sum(grp_man[0], grp_exp[0], grp_man[1], grp_exp[1], m01, e01);
    aligned_sum(grp_man[2], grp_exp[2], grp_man[3], grp_exp[3], m23, e23);
    aligned_sum(m01, e01, m23, e23, man, exp);
endfunction

// Expected result of one (b,c) pair over the whole V loop
function automatic void expected_pair_result(input int b, input int c, input int dim_v,
                                             input int left_base, input int right_base,
                                             output int man, output int exp);
    int l_nv;
    int r_nv;
    int dot_m;
    int dot_e;
    int acc_m;
    int acc_e;
    acc_m = 0;
    acc_e = 0;
    for (int v = 0; v < dim_v; v++) begin
        l_nv = wrapped_nv_index(left_base, b, dim_v, v);
        r_nv = wrapped_nv_index(right_base, c, dim_v, v);
        dot_of_nvs(l_nv, r_nv, dot_m, dot_e);
        if (v == 0) begin
            acc_m = dot_m;
            acc_e = dot_e;
        end else begin
            aligned_sum(acc_m, acc_e, dot_m, dot_e, acc_m, acc_e);
        end
    end
    man = acc_m;
    exp = acc_e;
endfunction

`endif

// File: test/gfp8_bcv_tb.sv
`timescale 1ns/1ps

module gfp8_bcv_tb import gfp8_pkg::*; ();

    localparam int NV_COUNT     = 1 << NV_IDX_W;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_WATCH   = 12;
    localparam int WD_MARGIN    = 200;
    localparam int EXP_HIGH     = 63;
    localparam int NUM_ROWS     = 5;
    localparam int FILL_CYCLES  = 2;
    localparam int STEP_CYCLES  = FILL_CYCLES + COMPUTE_LAT + 1;

    // Columns are B, C, V, left base line, right base line
    localparam int TILE_TABLE [NUM_ROWS][5] = '{
        '{1, 1, 1,   0,  12},
        '{2, 3, 4,  37, 163},
        '{3, 2, 5, 482, 272},
        '{1, 4, 2, 400, 511},
        '{2, 2, 3,  13, 178}
    };

    logic                       i_clk;
    logic                       i_reset_n;
    logic                       i_tile_en;
    logic [DIM_W-1:0]           i_dim_b;
    logic [DIM_W-1:0]           i_dim_c;
    logic [DIM_W-1:0]           i_dim_v;
    logic [ADDR_W-1:0]          i_left_base_addr;
    logic [ADDR_W-1:0]          i_right_base_addr;
    logic                       o_tile_done;
    logic [NV_IDX_W-1:0]        o_nv_left_rd_idx;
    logic [NV_IDX_W-1:0]        o_nv_right_rd_idx;
    nv_exp_u                    i_nv_left_exp;
    nv_exp_u                    i_nv_right_exp;
    nv_group_u [NV_GROUPS-1:0]  i_nv_left_man;
    nv_group_u [NV_GROUPS-1:0]  i_nv_right_man;
    logic signed [ACC_W-1:0]    o_result_mantissa;
    logic signed [EXP_W-1:0]    o_result_exponent;
    logic                       o_result_valid;

    // Tile memory with one entry per NV
    logic signed [MAN_W-1:0]    man_mem [NV_COUNT][NV_GROUPS][GROUP_ELEMS];
    logic [EXP_W-1:0]           exp_mem [NV_COUNT][NV_GROUPS];

    `include "gfp8_ref_model.svh"

    gfp8_bcv_top UUT (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_tile_en         (i_tile_en),
        .i_dim_b           (i_dim_b),
        .i_dim_c           (i_dim_c),
        .i_dim_v           (i_dim_v),
        .i_left_base_addr  (i_left_base_addr),
        .i_right_base_addr (i_right_base_addr),
        .o_tile_done       (o_tile_done),
        .o_nv_left_rd_idx  (o_nv_left_rd_idx),
        .i_nv_left_exp     (i_nv_left_exp),
        .i_nv_left_man     (i_nv_left_man),
        .o_nv_right_rd_idx (o_nv_right_rd_idx),
        .i_nv_right_exp    (i_nv_right_exp),
        .i_nv_right_man    (i_nv_right_man),
        .o_result_mantissa (o_result_mantissa),
        .o_result_exponent (o_result_exponent),
        .o_result_valid    (o_result_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // Memory answers the read indices without a clock
    always_comb begin
        for (int g = 0; g < NV_GROUPS; g++) begin
            i_nv_left_exp.exp[g]  = exp_mem[o_nv_left_rd_idx][g];
            i_nv_right_exp.exp[g] = exp_mem[o_nv_right_rd_idx][g];
            for (int e = 0; e < GROUP_ELEMS; e++) begin
                i_nv_left_man[g].man[e]  = man_mem[o_nv_left_rd_idx][g][e];
                i_nv_right_man[g].man[e] = man_mem[o_nv_right_rd_idx][g][e];
            end
        end
    end

    // ==============================
    // Helpers
    // ==============================
    task automatic check_value(input string name, input logic signed [63:0] expected,
                               input logic signed [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic fill_memory();
        for (int n = 0; n < NV_COUNT; n++) begin
            for (int g = 0; g < NV_GROUPS; g++) begin
                exp_mem[n][g] = EXP_W'($urandom_range(31, 0));
                for (int e = 0; e < GROUP_ELEMS; e++) begin
                    man_mem[n][g][e] = MAN_W'($urandom);
                end
            end
        end
        // Extreme exponents with groups far apart inside one NV
        for (int g = 0; g < NV_GROUPS; g++) begin
            exp_mem[3][g]   = (g % 2 == 0) ? EXP_W'(EXP_HIGH) : '0;
            exp_mem[44][g]  = (g % 2 == 0) ? EXP_W'(EXP_HIGH) : '0;
            // Whole NVs far above or below their V neighbours
            exp_mem[9][g]   = EXP_W'(EXP_HIGH);
            exp_mem[70][g]  = EXP_W'(EXP_HIGH);
            exp_mem[100][g] = '0;
        end
    endtask

    // Cycle budget over all table rows
    function automatic int watchdog_cycles();
        int total;
        total = RESET_CYCLES + 10;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += ((2 + COMPUTE_LAT + 1) * TILE_TABLE[r][2] + 1) *
                     TILE_TABLE[r][0] * TILE_TABLE[r][1];
            total += IDLE_WATCH + 10;
        end
        return total + WD_MARGIN;
    endfunction

    // One table row from command edge to done and idle watch
    task automatic run_tile(input int row);
        int dim_b;
        int dim_c;
        int dim_v;
        int seen;
        int m;
        int e;
        int cyc;
        int pair_len;
        int pair_idx;
        int step;
        int left_idx;
        int right_idx;
        bit glitched;
        int exp_man_q[$];
        int exp_exp_q[$];
        dim_b = TILE_TABLE[row][0];
        dim_c = TILE_TABLE[row][1];
        dim_v = TILE_TABLE[row][2];
        // b-major, c-minor result order
        for (int b = 0; b < dim_b; b++) begin
            for (int c = 0; c < dim_c; c++) begin
                expected_pair_result(b, c, dim_v, TILE_TABLE[row][3], TILE_TABLE[row][4],
                                     m, e);
                exp_man_q.push_back(m);
                exp_exp_q.push_back(e);
            end
        end
        @(negedge i_clk);
        i_dim_b           = DIM_W'(dim_b);
        i_dim_c           = DIM_W'(dim_c);
        i_dim_v           = DIM_W'(dim_v);
        i_left_base_addr  = ADDR_W'(TILE_TABLE[row][3]);
        i_right_base_addr = ADDR_W'(TILE_TABLE[row][4]);
        i_tile_en         = 1'b1;
        seen     = 0;
        glitched = 1'b0;
        cyc      = 0;
        pair_len = STEP_CYCLES * dim_v + 1;
        while (seen < dim_b * dim_c) begin
            @(negedge i_clk);
            check_value("o_tile_done", 0, o_tile_done);
            // Read indices are nonzero only in the two FILL cycles of each V step
            pair_idx  = cyc / pair_len;
            step      = cyc % pair_len;
            left_idx  = 0;
            right_idx = 0;
            if (pair_idx < dim_b * dim_c && step < STEP_CYCLES * dim_v &&
                    step % STEP_CYCLES < FILL_CYCLES) begin
                left_idx  = wrapped_nv_index(TILE_TABLE[row][3], pair_idx / dim_c, dim_v,
                                             step / STEP_CYCLES);
                right_idx = wrapped_nv_index(TILE_TABLE[row][4], pair_idx % dim_c, dim_v,
                                             step / STEP_CYCLES);
            end
            check_value("o_nv_left_rd_idx", left_idx, o_nv_left_rd_idx);
            check_value("o_nv_right_rd_idx", right_idx, o_nv_right_rd_idx);
            cyc++;
            // A second edge mid-tile must be ignored
            if (seen == 1 && !glitched) begin
                i_tile_en = 1'b0;
                glitched  = 1'b1;
            end else begin
                i_tile_en = 1'b1;
            end
            if (o_result_valid) begin
                check_value("o_result_mantissa", exp_man_q.pop_front(), o_result_mantissa);
                check_value("o_result_exponent", exp_exp_q.pop_front(), o_result_exponent);
                seen++;
            end
        end
        i_tile_en = 1'b1;
        @(negedge i_clk);
        check_value("o_result_valid", 0, o_result_valid);
        check_value("o_tile_done", 1, o_tile_done);
        // Enable still high so nothing may restart
        repeat (IDLE_WATCH) begin
            @(negedge i_clk);
            check_value("o_result_valid", 0, o_result_valid);
            check_value("o_tile_done", 0, o_tile_done);
        end
        i_tile_en = 1'b0;
    endtask

    // ==============================
    // Watchdog
    // ==============================
    initial begin
        #(watchdog_cycles() * CLK_PERIOD);
        $display("Timeout: the tiles did not finish within %0d cycles", watchdog_cycles());
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog expired");
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        i_reset_n         = 1'b0;
        i_tile_en         = 1'b0;
        i_dim_b           = '0;
        i_dim_c           = '0;
        i_dim_v           = '0;
        i_left_base_addr  = '0;
        i_right_base_addr = '0;
        void'($urandom(32'h78dc_fdd7));
        fill_memory();
        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_reset_n = 1'b1;
        // Quiet outputs before any tile
        repeat (4) begin
            @(negedge i_clk);
            check_value("o_result_valid", 0, o_result_valid);
            check_value("o_tile_done", 0, o_tile_done);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_tile(r);
        end
        repeat (2) @(negedge i_clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
